// ==== cpu_config.svh ====
// data and address widths, reset address
// opcode byte values of the supported instruction subset
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_DATA_W   8
`define CPU_ADDR_W   16
// first opcode fetch after reset, no vector read
`define CPU_RESET_PC 16'h0200

// immediate loads
`define CPU_OP_LDA_IMM 8'hA9
`define CPU_OP_LDX_IMM 8'hA2
`define CPU_OP_LDY_IMM 8'hA0
// register transfers
`define CPU_OP_TAX 8'hAA
`define CPU_OP_TAY 8'hA8
`define CPU_OP_TXA 8'h8A
`define CPU_OP_TYA 8'h98
// immediate arithmetic and logic
`define CPU_OP_ADC_IMM 8'h69
`define CPU_OP_AND_IMM 8'h29
`define CPU_OP_ORA_IMM 8'h09
`define CPU_OP_EOR_IMM 8'h49
// carry flag
`define CPU_OP_SEC 8'h38
`define CPU_OP_CLC 8'h18
// absolute store and jump
`define CPU_OP_STA_ABS 8'h8D
`define CPU_OP_JMP_ABS 8'h4C
`define CPU_OP_NOP     8'hEA

`endif

// ==== cpu_pkg.sv ====
// shared types of the core
// alu operation, status flags, writeback select, sequencer state
package cpu_pkg;

  // alu function select
  typedef enum logic [2:0] {
    ALU_ADC  = 3'd0,
    ALU_AND  = 3'd1,
    ALU_ORA  = 3'd2,
    ALU_EOR  = 3'd3,
    // forwards operand b
    ALU_PASS = 3'd4
  } aluOpT;

  // subset of the 6502 P register
  typedef struct packed {
    logic n;
    logic v;
    logic z;
    logic c;
  } statusT;

  // register written back in exec
  typedef enum logic [1:0] {
    REG_NONE = 2'd0,
    REG_A    = 2'd1,
    REG_X    = 2'd2,
    REG_Y    = 2'd3
  } regSelT;

  // one state per memory access, plus exec
  typedef enum logic [2:0] {
    ST_FETCH   = 3'd0,
    ST_OPERAND = 3'd1,
    ST_ADDRLO  = 3'd2,
    ST_ADDRHI  = 3'd3,
    ST_WRITE   = 3'd4,
    ST_EXEC    = 3'd5
  } seqStateT;

endpackage

// ==== memBusIf.sv ====
// memBusIf, one memory access from sequencer to bus unit
`timescale 1ns/1ps
`include "cpu_config.svh"

interface memBusIf;
  // request side, held from start until done
  logic                   start;
  logic [`CPU_ADDR_W-1:0] addr;
  logic [`CPU_DATA_W-1:0] wdata;
  logic                   write;
  // completion, rdata valid with done
  logic                   done;
  logic [`CPU_DATA_W-1:0] rdata;

  // sequencer side
  modport master (
    output start, addr, wdata, write,
    input  done, rdata
  );

  // bus unit side
  modport slave (
    input  start, addr, wdata, write,
    output done, rdata
  );
endinterface

// ==== busUnit.sv ====
// busUnit, four-phase req/ack handshake for one access
`timescale 1ns/1ps
`include "cpu_config.svh"

module busUnit (
  input  logic                   clk,
  input  logic                   rst,
  memBusIf.slave                 bus,
  output logic                   memReq,
  output logic                   memWrite,
  output logic [`CPU_ADDR_W-1:0] memAddr,
  output logic [`CPU_DATA_W-1:0] memWdata,
  input  logic                   memAck,
  input  logic [`CPU_DATA_W-1:0] memRdata
);

  typedef enum logic [1:0] {
    BU_IDLE    = 2'd0,
    BU_REQUEST = 2'd1,
    BU_RELEASE = 2'd2
  } buStateT;

  buStateT state;
  logic doneReg;
  logic [`CPU_DATA_W-1:0] rdataReg;

  assign bus.done  = doneReg;
  assign bus.rdata = rdataReg;

  // control path
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= BU_IDLE;
      memReq   <= 1'b0;
      memWrite <= 1'b0;
      doneReg  <= 1'b0;
    end else begin
      doneReg <= 1'b0;
      case (state)
        BU_IDLE: begin
          // ack is already low here, last access waited for it
          if (bus.start) begin
            memReq   <= 1'b1;
            memWrite <= bus.write;
            state    <= BU_REQUEST;
          end
        end
        BU_REQUEST: begin
          if (memAck) begin
            memReq <= 1'b0;
            state  <= BU_RELEASE;
          end
        end
        default: begin
          // wait for memory to drop ack
          if (!memAck) begin
            memWrite <= 1'b0;
            doneReg  <= 1'b1;
            state    <= BU_IDLE;
          end
        end
      endcase
    end
  end

  // address, write data and read data
  always_ff @(posedge clk) begin
    if (state == BU_IDLE && bus.start) begin
      memAddr  <= bus.addr;
      memWdata <= bus.wdata;
    end
    // read byte is valid while ack is high
    if (state == BU_REQUEST && memAck) begin
      rdataReg <= memRdata;
    end
  end

endmodule

// ==== programCounter.sv ====
// programCounter, PC register with incrementer and jump load
`timescale 1ns/1ps
`include "cpu_config.svh"

module programCounter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inc,
  input  logic                   load,
  input  logic [`CPU_ADDR_W-1:0] jumpAddr,
  output logic [`CPU_ADDR_W-1:0] pc
);

  logic [`CPU_ADDR_W-1:0] pcNext;

  // incrementer, carries across both bytes
  assign pcNext = pc + {{(`CPU_ADDR_W-1){1'b0}}, 1'b1};

  always_ff @(posedge clk) begin
    if (rst) begin
      // start straight at the program, no vector fetch
      pc <= `CPU_RESET_PC;
    end else if (load) begin
      // jmp target has priority
      pc <= jumpAddr;
    end else if (inc) begin
      pc <= pcNext;
    end
  end

endmodule

// ==== alu.sv ====
// alu, binary add with carry and bitwise logic
// flag results for N, Z, C and V
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu (
  input  cpu_pkg::aluOpT         op,
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  input  logic                   carryIn,
  output logic [`CPU_DATA_W-1:0] result,
  output cpu_pkg::statusT        flagsOut
);

  logic [`CPU_DATA_W:0] sum;
  logic                 overflow;

  // 9 bit sum, top bit is carry out
  assign sum = {1'b0, a} + {1'b0, b} + {{`CPU_DATA_W{1'b0}}, carryIn};

  // signed overflow when both inputs agree in sign and the sum does not
  assign overflow = (a[`CPU_DATA_W-1] == b[`CPU_DATA_W-1]) &&
                    (sum[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);

  always_comb begin
    // logic ops pass carry through, v only meaningful for adc
    flagsOut.c = carryIn;
    flagsOut.v = 1'b0;
    case (op)
      cpu_pkg::ALU_ADC: begin
        result     = sum[`CPU_DATA_W-1:0];
        flagsOut.c = sum[`CPU_DATA_W];
        flagsOut.v = overflow;
      end
      cpu_pkg::ALU_AND: result = a & b;
      cpu_pkg::ALU_ORA: result = a | b;
      cpu_pkg::ALU_EOR: result = a ^ b;
      // loads, transfers and store data
      default:          result = b;
    endcase
    // n and z follow the result in every case
    flagsOut.n = result[`CPU_DATA_W-1];
    flagsOut.z = (result == '0);
  end

endmodule

// ==== registerFile.sv ====
// registerFile, A, X and Y plus the N V Z C status register
// writeback and flag update strobes
`timescale 1ns/1ps
`include "cpu_config.svh"

module registerFile (
  input  logic                   clk,
  input  logic                   rst,
  input  cpu_pkg::regSelT        dest,
  input  logic [`CPU_DATA_W-1:0] wdata,
  input  cpu_pkg::statusT        flagsIn,
  input  logic                   updateNz,
  input  logic                   updateCv,
  input  logic                   setCarry,
  input  logic                   clearCarry,
  output logic [`CPU_DATA_W-1:0] accum,
  output logic [`CPU_DATA_W-1:0] xReg,
  output logic [`CPU_DATA_W-1:0] yReg,
  output cpu_pkg::statusT        flags
);

  // data registers
  always_ff @(posedge clk) begin
    if (rst) begin
      accum <= '0;
      xReg  <= '0;
      yReg  <= '0;
    end else begin
      case (dest)
        cpu_pkg::REG_A: accum <= wdata;
        cpu_pkg::REG_X: xReg  <= wdata;
        cpu_pkg::REG_Y: yReg  <= wdata;
        default: ;
      endcase
    end
  end

  // status register
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      if (updateNz) begin
        flags.n <= flagsIn.n;
        flags.z <= flagsIn.z;
      end
      if (updateCv) begin
        flags.c <= flagsIn.c;
        flags.v <= flagsIn.v;
      end
      // sec / clc override any alu carry
      if (setCarry) begin
        flags.c <= 1'b1;
      end else if (clearCarry) begin
        flags.c <= 1'b0;
      end
    end
  end

endmodule

// ==== sequencer.sv ====
// sequencer, instruction register, decode and cycle FSM
// one state per memory access, exec applies the writeback
`timescale 1ns/1ps
`include "cpu_config.svh"

module sequencer (
  input  logic                   clk,
  input  logic                   rst,
  memBusIf.master                bus,
  input  logic [`CPU_ADDR_W-1:0] pc,
  output logic                   pcInc,
  output logic                   pcLoad,
  output logic [`CPU_ADDR_W-1:0] jumpAddr,
  output cpu_pkg::aluOpT         aluOp,
  output logic [`CPU_DATA_W-1:0] aluA,
  output logic [`CPU_DATA_W-1:0] aluB,
  input  logic [`CPU_DATA_W-1:0] aluResult,
  input  logic [`CPU_DATA_W-1:0] accum,
  input  logic [`CPU_DATA_W-1:0] xReg,
  input  logic [`CPU_DATA_W-1:0] yReg,
  output cpu_pkg::regSelT        dest,
  output logic                   updateNz,
  output logic                   updateCv,
  output logic                   setCarry,
  output logic                   clearCarry,
  output logic                   sync
);

  cpu_pkg::seqStateT state;
  logic pending;
  logic [`CPU_DATA_W-1:0] ir;
  logic [`CPU_DATA_W-1:0] operand;
  logic [`CPU_DATA_W-1:0] addrLo;
  logic [`CPU_DATA_W-1:0] addrHi;
  logic isExec;
  cpu_pkg::regSelT decDest;
  logic decNz;
  logic decCv;
  logic decSec;
  logic decClc;

  // state after the opcode byte, undefined opcodes act as one byte nop
  function automatic cpu_pkg::seqStateT afterFetch(input logic [`CPU_DATA_W-1:0] op);
    case (op)
      `CPU_OP_LDA_IMM, `CPU_OP_LDX_IMM, `CPU_OP_LDY_IMM,
      `CPU_OP_ADC_IMM, `CPU_OP_AND_IMM, `CPU_OP_ORA_IMM,
      `CPU_OP_EOR_IMM: afterFetch = cpu_pkg::ST_OPERAND;
      `CPU_OP_STA_ABS, `CPU_OP_JMP_ABS: afterFetch = cpu_pkg::ST_ADDRLO;
      default: afterFetch = cpu_pkg::ST_EXEC;
    endcase
  endfunction

  assign isExec = (state == cpu_pkg::ST_EXEC);

  // every state but exec owns one access
  // pending keeps a second start out until done
  assign bus.start = !isExec && !pending;
  assign bus.write = (state == cpu_pkg::ST_WRITE);
  assign bus.addr  = bus.write ? {addrHi, addrLo} : pc;
  // store data is accum passed through the alu
  assign bus.wdata = aluResult;

  // sync covers the opcode fetch handshake
  assign sync = pending && (state == cpu_pkg::ST_FETCH);

  // pc steps after each program byte, pc stays put during the access
  assign pcInc    = bus.done && !bus.write && !isExec;
  assign pcLoad   = isExec && (ir == `CPU_OP_JMP_ABS);
  assign jumpAddr = {addrHi, addrLo};

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= cpu_pkg::ST_FETCH;
      pending <= 1'b0;
    end else begin
      if (bus.start) begin
        pending <= 1'b1;
      end else if (bus.done) begin
        pending <= 1'b0;
      end
      case (state)
        cpu_pkg::ST_FETCH:   if (bus.done) state <= afterFetch(bus.rdata);
        cpu_pkg::ST_OPERAND: if (bus.done) state <= cpu_pkg::ST_EXEC;
        cpu_pkg::ST_ADDRLO:  if (bus.done) state <= cpu_pkg::ST_ADDRHI;
        cpu_pkg::ST_ADDRHI: begin
          // jmp has no data access
          if (bus.done) begin
            state <= (ir == `CPU_OP_JMP_ABS) ? cpu_pkg::ST_EXEC : cpu_pkg::ST_WRITE;
          end
        end
        cpu_pkg::ST_WRITE:   if (bus.done) state <= cpu_pkg::ST_EXEC;
        default:             state <= cpu_pkg::ST_FETCH;
      endcase
    end
  end

  // instruction bytes, captured with done
  always_ff @(posedge clk) begin
    if (bus.done) begin
      case (state)
        cpu_pkg::ST_FETCH:   ir      <= bus.rdata;
        cpu_pkg::ST_OPERAND: operand <= bus.rdata;
        cpu_pkg::ST_ADDRLO:  addrLo  <= bus.rdata;
        cpu_pkg::ST_ADDRHI:  addrHi  <= bus.rdata;
        default: ;
      endcase
    end
  end

  // decode of the latched opcode
  always_comb begin
    aluOp   = cpu_pkg::ALU_PASS;
    aluB    = operand;
    decDest = cpu_pkg::REG_NONE;
    decNz   = 1'b0;
    decCv   = 1'b0;
    decSec  = 1'b0;
    decClc  = 1'b0;
    case (ir)
      `CPU_OP_LDA_IMM: begin decDest = cpu_pkg::REG_A; decNz = 1'b1; end
      `CPU_OP_LDX_IMM: begin decDest = cpu_pkg::REG_X; decNz = 1'b1; end
      `CPU_OP_LDY_IMM: begin decDest = cpu_pkg::REG_Y; decNz = 1'b1; end
      `CPU_OP_TAX: begin aluB = accum; decDest = cpu_pkg::REG_X; decNz = 1'b1; end
      `CPU_OP_TAY: begin aluB = accum; decDest = cpu_pkg::REG_Y; decNz = 1'b1; end
      `CPU_OP_TXA: begin aluB = xReg; decDest = cpu_pkg::REG_A; decNz = 1'b1; end
      `CPU_OP_TYA: begin aluB = yReg; decDest = cpu_pkg::REG_A; decNz = 1'b1; end
      `CPU_OP_ADC_IMM: begin
        aluOp   = cpu_pkg::ALU_ADC;
        decDest = cpu_pkg::REG_A;
        decNz   = 1'b1;
        decCv   = 1'b1;
      end
      `CPU_OP_AND_IMM: begin aluOp = cpu_pkg::ALU_AND; decDest = cpu_pkg::REG_A; decNz = 1'b1; end
      `CPU_OP_ORA_IMM: begin aluOp = cpu_pkg::ALU_ORA; decDest = cpu_pkg::REG_A; decNz = 1'b1; end
      `CPU_OP_EOR_IMM: begin aluOp = cpu_pkg::ALU_EOR; decDest = cpu_pkg::REG_A; decNz = 1'b1; end
      `CPU_OP_SEC: decSec = 1'b1;
      `CPU_OP_CLC: decClc = 1'b1;
      // accum to the write data path
      `CPU_OP_STA_ABS: aluB = accum;
      default: ;
    endcase
  end

  // accumulator is always operand a
  assign aluA = accum;

  // writeback strobes only in exec
  assign dest       = isExec ? decDest : cpu_pkg::REG_NONE;
  assign updateNz   = isExec && decNz;
  assign updateCv   = isExec && decCv;
  assign setCarry   = isExec && decSec;
  assign clearCarry = isExec && decClc;

endmodule

// ==== cpu6502Core.sv ====
// cpu6502Core top, bus unit, sequencer, PC, ALU and registers
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu6502Core (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   memReq,
  output logic                   memWrite,
  output logic [`CPU_ADDR_W-1:0] memAddr,
  output logic [`CPU_DATA_W-1:0] memWdata,
  input  logic                   memAck,
  input  logic [`CPU_DATA_W-1:0] memRdata,
  output logic                   sync,
  output logic [`CPU_DATA_W-1:0] accum,
  output logic [`CPU_DATA_W-1:0] xReg,
  output logic [`CPU_DATA_W-1:0] yReg,
  output cpu_pkg::statusT        flags
);

  // pc control
  logic                   pcInc;
  logic                   pcLoad;
  logic [`CPU_ADDR_W-1:0] jumpAddr;
  logic [`CPU_ADDR_W-1:0] pc;
  // alu path, result doubles as writeback and store data
  cpu_pkg::aluOpT         aluOp;
  logic [`CPU_DATA_W-1:0] aluA;
  logic [`CPU_DATA_W-1:0] aluB;
  logic [`CPU_DATA_W-1:0] aluResult;
  cpu_pkg::statusT        aluFlags;
  // writeback strobes
  cpu_pkg::regSelT        dest;
  logic                   updateNz;
  logic                   updateCv;
  logic                   setCarry;
  logic                   clearCarry;

  memBusIf memBus ();

  busUnit uBus (
    .clk(clk), .rst(rst), .bus(memBus.slave),
    .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
    .memWdata(memWdata), .memAck(memAck), .memRdata(memRdata)
  );

  sequencer uSeq (
    .clk(clk), .rst(rst), .bus(memBus.master), .pc(pc),
    .pcInc(pcInc), .pcLoad(pcLoad), .jumpAddr(jumpAddr),
    .aluOp(aluOp), .aluA(aluA), .aluB(aluB), .aluResult(aluResult),
    .accum(accum), .xReg(xReg), .yReg(yReg),
    .dest(dest), .updateNz(updateNz), .updateCv(updateCv),
    .setCarry(setCarry), .clearCarry(clearCarry), .sync(sync)
  );

  programCounter uPc (
    .clk(clk), .rst(rst), .inc(pcInc), .load(pcLoad),
    .jumpAddr(jumpAddr), .pc(pc)
  );

  // carry in always comes from the status register
  alu uAlu (
    .op(aluOp), .a(aluA), .b(aluB), .carryIn(flags.c),
    .result(aluResult), .flagsOut(aluFlags)
  );

  registerFile uRegs (
    .clk(clk), .rst(rst), .dest(dest), .wdata(aluResult), .flagsIn(aluFlags),
    .updateNz(updateNz), .updateCv(updateCv),
    .setCarry(setCarry), .clearCarry(clearCarry),
    .accum(accum), .xReg(xReg), .yReg(yReg), .flags(flags)
  );

endmodule

// ==== cpu_properties.sv ====
// cpuProperties, req/ack handshake and opcode fetch assertions
// bound to every cpu6502Core instance
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuProperties (
  input logic                   clk,
  input logic                   rst,
  input logic                   memReq,
  input logic                   memWrite,
  input logic [`CPU_ADDR_W-1:0] memAddr,
  input logic [`CPU_DATA_W-1:0] memWdata,
  input logic                   memAck,
  input logic                   sync
);

  // read by the testbench for its closing count
  int failCount = 0;
  // set once the first request after reset has been seen
  logic seenReq;

  always_ff @(posedge clk) begin
    if (rst) begin
      seenReq <= 1'b0;
    end else if (memReq) begin
      seenReq <= 1'b1;
    end
  end

  // req held until memory answers
  reqHeld: assert property (@(posedge clk) disable iff (rst)
    memReq && !memAck |=> memReq)
    else begin
      failCount++;
      $error("memReq dropped before memAck");
    end

  // address and data frozen during the handshake
  reqStable: assert property (@(posedge clk) disable iff (rst)
    memReq && $past(memReq) |-> $stable(memAddr) && $stable(memWrite) && $stable(memWdata))
    else begin
      failCount++;
      $error("request fields changed while memReq was high");
    end

  // a new request waits for ack to fall
  noRiseOnAck: assert property (@(posedge clk) disable iff (rst)
    memAck |=> !$rose(memReq))
    else begin
      failCount++;
      $error("memReq rose while memAck was still high");
    end

  firstFetch: assert property (@(posedge clk) disable iff (rst)
    !seenReq && memReq |-> !memWrite && sync && memAddr == `CPU_RESET_PC)
    else begin
      failCount++;
      $error("first request after reset was not an opcode read at the reset address");
    end

  // sync starts with the request and never marks a write
  syncWithReq: assert property (@(posedge clk) disable iff (rst)
    $rose(sync) |-> $rose(memReq) && !memWrite)
    else begin
      failCount++;
      $error("sync rose without a new read request");
    end

endmodule

bind cpu6502Core cpuProperties props (
  .clk(clk), .rst(rst), .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
  .memWdata(memWdata), .memAck(memAck), .sync(sync)
);

// ==== cpu_tb.sv ====
// testbench for the core with clock, reset and program memory with LFSR ack delays
// expected register state at each opcode fetch and the closing report
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;

  localparam int WaitLimit = 64;

  typedef struct packed {
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] x;
    logic [`CPU_DATA_W-1:0] y;
    logic [3:0]             f;
  } stepT;

  logic                   clk;
  logic                   rst;
  logic                   memReq;
  logic                   memWrite;
  logic [`CPU_ADDR_W-1:0] memAddr;
  logic [`CPU_DATA_W-1:0] memWdata;
  logic                   memAck;
  logic [`CPU_DATA_W-1:0] memRdata;
  logic                   sync;
  logic [`CPU_DATA_W-1:0] accum;
  logic [`CPU_DATA_W-1:0] xReg;
  logic [`CPU_DATA_W-1:0] yReg;
  cpu_pkg::statusT        flags;

  logic [7:0] mem [65536];
  logic [7:0] progBytes [$];
  stepT expected [$];
  logic [`CPU_ADDR_W-1:0] writeAddrs [$];
  logic [`CPU_DATA_W-1:0] writeData [$];
  logic [31:0] lfsr = 32'h4c18;
  int errors = 0;
  int memErrors = 0;

  cpu6502Core uut (
    .clk(clk), .rst(rst), .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
    .memWdata(memWdata), .memAck(memAck), .memRdata(memRdata), .sync(sync),
    .accum(accum), .xReg(xReg), .yReg(yReg), .flags(flags)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // fibonacci lfsr x^32 + x^22 + x^2 + x + 1
  function automatic logic randBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // samples 1 ns after each edge until sync rises
  task automatic waitSyncRise(output bit found);
    int n;
    logic was;
    found = 1'b0;
    n = 0;
    was = sync;
    while (!found && n < WaitLimit) begin
      @(posedge clk);
      #1;
      found = sync && !was;
      was = sync;
      n++;
    end
  endtask

  task automatic checkState(input int k, input stepT s);
    assert (memAddr == s.addr) else begin
      errors++;
      $display("Fail memAddr at step %0d got %h expected %h", k, memAddr, s.addr);
    end
    assert (accum == s.a) else begin
      errors++;
      $display("Fail accum at step %0d got %h expected %h", k, accum, s.a);
    end
    assert (xReg == s.x) else begin
      errors++;
      $display("Fail xReg at step %0d got %h expected %h", k, xReg, s.x);
    end
    assert (yReg == s.y) else begin
      errors++;
      $display("Fail yReg at step %0d got %h expected %h", k, yReg, s.y);
    end
    assert (flags == s.f) else begin
      errors++;
      $display("Fail flags at step %0d got %h expected %h", k, flags, s.f);
    end
  endtask

  // four-phase memory with ack after 0 to 3 cycles
  // ack also falls 0 to 3 cycles after req drops
  initial begin : memoryModel
    logic [1:0] delay;
    logic [1:0] holdDelay;
    int n;
    bit hung;
    memAck = 1'b0;
    memRdata = '0;
    hung = 1'b0;
    while (!hung) begin
      n = 0;
      @(posedge clk);
      #1;
      while (!memReq && n < WaitLimit) begin
        @(posedge clk);
        #1;
        n++;
      end
      if (!memReq) begin
        memErrors++;
        $display("memory saw no request for %0d cycles", WaitLimit);
        hung = 1'b1;
      end else begin
        delay[1] = randBit();
        delay[0] = randBit();
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        if (memWrite) begin
          writeAddrs.push_back(memAddr);
          writeData.push_back(memWdata);
        end else begin
          memRdata = mem[memAddr];
        end
        memAck = 1'b1;
        // ack stays up at least until req falls
        n = 0;
        while (memReq && n < WaitLimit) begin
          @(posedge clk);
          #1;
          n++;
        end
        if (memReq) begin
          memErrors++;
          $display("memReq stayed high for %0d cycles after memAck", WaitLimit);
          hung = 1'b1;
        end else begin
          // late ack release holds off the next request
          holdDelay[1] = randBit();
          holdDelay[0] = randBit();
          repeat (holdDelay) begin
            @(posedge clk);
            #1;
          end
        end
        memAck = 1'b0;
      end
    end
  end

  initial begin : mainSequence
    int k;
    bit found;
    rst = 1'b1;
    for (int i = 0; i < 65536; i++) begin
      // background depends on every address bit
      mem[i[15:0]] = i[15:8] ^ i[7:0];
    end
    progBytes = '{
      `CPU_OP_LDA_IMM, 8'h80, `CPU_OP_TAX, `CPU_OP_LDY_IMM, 8'h00, `CPU_OP_TYA,
      `CPU_OP_SEC, `CPU_OP_LDA_IMM, 8'h7F, `CPU_OP_ADC_IMM, 8'h00, `CPU_OP_SEC,
      `CPU_OP_LDA_IMM, 8'h5A, `CPU_OP_AND_IMM, 8'h0F, `CPU_OP_ORA_IMM, 8'hF0,
      `CPU_OP_EOR_IMM, 8'hFF, `CPU_OP_AND_IMM, 8'h00, `CPU_OP_CLC,
      `CPU_OP_LDA_IMM, 8'hFF, `CPU_OP_ADC_IMM, 8'h01, `CPU_OP_LDX_IMM, 8'h3C,
      `CPU_OP_TXA, `CPU_OP_TAY, `CPU_OP_NOP, 8'hFF, `CPU_OP_LDA_IMM, 8'hC3,
      `CPU_OP_STA_ABS, 8'h34, 8'h12, `CPU_OP_JMP_ABS, 8'h00, 8'h03
    };
    for (int i = 0; i < progBytes.size(); i++) begin
      mem[`CPU_RESET_PC + i[15:0]] = progBytes[i];
    end
    // endless jmp to itself at 0300
    mem[16'h0300] = `CPU_OP_JMP_ABS;
    mem[16'h0301] = 8'h00;
    mem[16'h0302] = 8'h03;
    // state left by the previous instruction at each sync rise
    // columns are fetch address, A, X, Y and flags NVZC
    expected = '{
      {16'h0200, 8'h00, 8'h00, 8'h00, 4'b0000}, {16'h0202, 8'h80, 8'h00, 8'h00, 4'b1000},
      {16'h0203, 8'h80, 8'h80, 8'h00, 4'b1000}, {16'h0205, 8'h80, 8'h80, 8'h00, 4'b0010},
      {16'h0206, 8'h00, 8'h80, 8'h00, 4'b0010}, {16'h0207, 8'h00, 8'h80, 8'h00, 4'b0011},
      {16'h0209, 8'h7F, 8'h80, 8'h00, 4'b0001}, {16'h020B, 8'h80, 8'h80, 8'h00, 4'b1100},
      {16'h020C, 8'h80, 8'h80, 8'h00, 4'b1101}, {16'h020E, 8'h5A, 8'h80, 8'h00, 4'b0101},
      {16'h0210, 8'h0A, 8'h80, 8'h00, 4'b0101}, {16'h0212, 8'hFA, 8'h80, 8'h00, 4'b1101},
      {16'h0214, 8'h05, 8'h80, 8'h00, 4'b0101}, {16'h0216, 8'h00, 8'h80, 8'h00, 4'b0111},
      {16'h0217, 8'h00, 8'h80, 8'h00, 4'b0110}, {16'h0219, 8'hFF, 8'h80, 8'h00, 4'b1100},
      {16'h021B, 8'h00, 8'h80, 8'h00, 4'b0011}, {16'h021D, 8'h00, 8'h3C, 8'h00, 4'b0001},
      {16'h021E, 8'h3C, 8'h3C, 8'h00, 4'b0001}, {16'h021F, 8'h3C, 8'h3C, 8'h3C, 4'b0001},
      {16'h0220, 8'h3C, 8'h3C, 8'h3C, 4'b0001}, {16'h0221, 8'h3C, 8'h3C, 8'h3C, 4'b0001},
      {16'h0223, 8'hC3, 8'h3C, 8'h3C, 4'b1001}, {16'h0226, 8'hC3, 8'h3C, 8'h3C, 4'b1001},
      {16'h0300, 8'hC3, 8'h3C, 8'h3C, 4'b1001}, {16'h0300, 8'hC3, 8'h3C, 8'h3C, 4'b1001}
    };
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    k = 0;
    found = 1'b1;
    while (found && k < expected.size()) begin
      waitSyncRise(found);
      if (found) begin
        checkState(k, expected[k]);
        k++;
      end else begin
        errors++;
        $display("no opcode fetch within %0d cycles before step %0d", WaitLimit, k);
      end
    end
    // the only store is STA $1234 with A = C3
    assert (writeAddrs.size() == 1) else begin
      errors++;
      $display("expected one memory write, saw %0d", writeAddrs.size());
    end
    if (writeAddrs.size() > 0) begin
      assert (writeAddrs[0] == 16'h1234) else begin
        errors++;
        $display("Fail store memAddr got %h expected %h", writeAddrs[0], 16'h1234);
      end
      assert (writeData[0] == 8'hC3) else begin
        errors++;
        $display("Fail store memWdata got %h expected %h", writeData[0], 8'hC3);
      end
    end
    $display("errors: %0d checks, %0d memory, %0d assertions",
             errors, memErrors, uut.props.failCount);
    if (errors + memErrors + uut.props.failCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
cpu_pkg.sv
memBusIf.sv
busUnit.sv
programCounter.sv
alu.sv
registerFile.sv
sequencer.sv
cpu6502Core.sv
cpu_properties.sv
cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the core with its testbench in Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module cpu_tb -o simv

# assertion errors are counted by the testbench instead of stopping the run
out=$(./obj_dir/simv +verilator+error+limit+1000)
echo "$out"

# exit status follows the pass line
echo "$out" | grep -qx "TEST OK"
